/* include/dcache_cfg.svh */
`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

// word address, no byte offset
`define ADDR_W 10

// one 32-bit word per line
`define DATA_W 32

// low address bits pick the set
`define SET_W 3

// the rest of the address is the tag
`define TAG_W (`ADDR_W - `SET_W)

// associativity
// the plru tree assumes exactly four
`define WAYS 4
`define WAY_W 2

// cycles a memory strobe stays up
`define MEM_LAT 5

`endif

/* logic/dcache_pkg.sv */
`include "dcache_cfg.svh"

package dcache_pkg;

	// address and data words
	typedef logic [`ADDR_W-1:0] addr_t;
	typedef logic [`DATA_W-1:0] data_t;

	// address fields
	typedef logic [`SET_W-1:0] set_t;
	typedef logic [`TAG_W-1:0] tag_t;

	// way number and plru bits of one set
	typedef logic [`WAY_W-1:0] way_t;
	typedef logic [`WAYS-2:0] tree_t;

	// memory strobe countdown
	// wide enough to hold MEM_LAT-1
	typedef logic [2:0] lat_cnt_t;

	// controller states
	typedef enum logic [2:0] {
		IDLE,
		LOOKUP,
		EVICT,
		REFILL,
		FILL_WRITE,
		RESPOND
	} ctrl_state_t;

endpackage

/* logic/dcache_if.sv */
// lookup and line access between controller and line store
interface way_lookup_if import dcache_pkg::*; ();
	// held request
	set_t set;
	tag_t tag;
	// line read port and write strobe
	way_t sel_way;
	logic wr_line;
	way_t wr_way;
	tag_t wr_tag;
	data_t wr_data;
	logic wr_dirty;
	logic clr_dirty;
	// combinational answers from the store
	logic hit;
	way_t hit_way;
	logic free_found;
	way_t free_way;
	data_t line_data;
	tag_t line_tag;
	logic line_dirty;

	modport ctrl (output set, tag, sel_way, wr_line, wr_way, wr_tag, wr_data, wr_dirty,
		clr_dirty, input hit, hit_way, free_found, free_way, line_data, line_tag, line_dirty);
	modport store (input set, tag, sel_way, wr_line, wr_way, wr_tag, wr_data, wr_dirty,
		clr_dirty, output hit, hit_way, free_found, free_way, line_data, line_tag, line_dirty);
endinterface

// replacement tree access
interface plru_if import dcache_pkg::*; ();
	set_t set;
	logic touch;
	way_t touch_way;
	way_t victim;

	modport ctrl (output set, touch, touch_way, input victim);
	modport tree (input set, touch, touch_way, output victim);
endinterface

/* logic/line_store.sv */
`include "dcache_cfg.svh"

module line_store import dcache_pkg::*; (
	input logic clk,
	input logic rst,
	way_lookup_if.store lk
);

	// per line state, indexed [set][way]
	logic [`WAYS-1:0] valid_q [(1 << `SET_W)];
	logic dirty_mem [(1 << `SET_W)][`WAYS];
	tag_t tag_mem [(1 << `SET_W)][`WAYS];
	data_t data_mem [(1 << `SET_W)][`WAYS];

	// tag compare over the valid ways of the set
	always_comb begin
		lk.hit = 1'b0;
		lk.hit_way = '0;
		for (int w = 0; w < `WAYS; w++) begin
			if (valid_q[lk.set][w] && (tag_mem[lk.set][w] == lk.tag)) begin
				lk.hit = 1'b1;
				lk.hit_way = way_t'(w);
			end
		end
	end

	// lowest invalid way
	// scan downward so the lowest one is kept
	always_comb begin
		lk.free_found = 1'b0;
		lk.free_way = '0;
		for (int w = `WAYS - 1; w >= 0; w--) begin
			if (!valid_q[lk.set][w]) begin
				lk.free_found = 1'b1;
				lk.free_way = way_t'(w);
			end
		end
	end

	// read port on sel_way
	assign lk.line_data = data_mem[lk.set][lk.sel_way];
	assign lk.line_tag = tag_mem[lk.set][lk.sel_way];
	// stale dirty bit of an invalid line never counts
	assign lk.line_dirty = valid_q[lk.set][lk.sel_way] & dirty_mem[lk.set][lk.sel_way];

	// valid bits, cleared on reset
	always_ff @(posedge clk) begin
		if (!rst) begin
			for (int s = 0; s < (1 << `SET_W); s++) begin
				valid_q[s] <= '0;
			end
		end else if (lk.wr_line) begin
			valid_q[lk.set][lk.wr_way] <= 1'b1;
		end
	end

	// tag and data words
	always_ff @(posedge clk) begin
		if (lk.wr_line) begin
			tag_mem[lk.set][lk.wr_way] <= lk.wr_tag;
			data_mem[lk.set][lk.wr_way] <= lk.wr_data;
		end
	end

	// dirty bits
	// a line write wins over a clear of the same line
	always_ff @(posedge clk) begin
		if (lk.clr_dirty) begin
			dirty_mem[lk.set][lk.sel_way] <= 1'b0;
		end
		if (lk.wr_line) begin
			dirty_mem[lk.set][lk.wr_way] <= lk.wr_dirty;
		end
	end

endmodule

/* logic/plru_tree.sv */
`include "dcache_cfg.svh"

module plru_tree import dcache_pkg::*; (
	input logic clk,
	input logic rst,
	plru_if.tree lru
);

	// one tree per set
	// bit 0 picks the half, bit 1 the pair 0/1, bit 2 the pair 2/3
	tree_t tree_q [(1 << `SET_W)];
	tree_t cur_tree;
	tree_t next_tree;

	assign cur_tree = tree_q[lru.set];

	// follow the bits down to a leaf
	always_comb begin
		if (!cur_tree[0]) begin
			lru.victim = {1'b0, cur_tree[1]};
		end else begin
			lru.victim = {1'b1, cur_tree[2]};
		end
	end

	// point every bit on the touched path away from it
	always_comb begin
		next_tree = cur_tree;
		if (!lru.touch_way[1]) begin
			// touched the lower pair, evict from the upper half next
			next_tree[0] = 1'b1;
			next_tree[1] = ~lru.touch_way[0];
		end else begin
			next_tree[0] = 1'b0;
			next_tree[2] = ~lru.touch_way[0];
		end
	end

	// all zero after reset, so way 0 is the first victim
	always_ff @(posedge clk) begin
		if (!rst) begin
			for (int s = 0; s < (1 << `SET_W); s++) begin
				tree_q[s] <= '0;
			end
		end else if (lru.touch) begin
			tree_q[lru.set] <= next_tree;
		end
	end

endmodule

/* logic/dcache_ctrl.sv */
`include "dcache_cfg.svh"

module dcache_ctrl import dcache_pkg::*; (
	input logic clk,
	input logic rst,
	input logic rd_en,
	input logic wr_en,
	input addr_t addr,
	input data_t wr_data,
	output data_t rd_data,
	output logic busy,
	output logic valid,
	output logic mem_rd_en,
	output logic mem_wr_en,
	output addr_t mem_addr,
	output data_t mem_wr_data,
	input data_t mem_rd_data,
	way_lookup_if.ctrl lk,
	plru_if.ctrl lru
);

	ctrl_state_t state_q;
	lat_cnt_t cnt_q;
	logic is_wr_q;
	logic accept;
	logic victim_dirty;
	logic mem_last;
	// held request
	addr_t addr_q;
	data_t wdata_q;
	set_t req_set;
	tag_t req_tag;
	// way picked in LOOKUP, kept for the memory phases
	way_t pick_way;
	way_t way_q;
	data_t rd_q;

	// exactly one strobe, and only while idle
	assign accept = (state_q == IDLE) && (rd_en ^ wr_en);

	assign req_set = addr_q[`SET_W-1:0];
	assign req_tag = addr_q[`ADDR_W-1:`SET_W];

	// hit first, then an empty way, then the plru victim
	always_comb begin
		if (lk.hit) begin
			pick_way = lk.hit_way;
		end else if (lk.free_found) begin
			pick_way = lk.free_way;
		end else begin
			pick_way = lru.victim;
		end
	end

	// only a real victim can need a write-back
	assign victim_dirty = !lk.hit && !lk.free_found && lk.line_dirty;
	assign mem_last = (cnt_q == '0);

	// store and tree requests
	always_comb begin
		lk.set = req_set;
		lk.tag = req_tag;
		lk.sel_way = (state_q == LOOKUP) ? pick_way : way_q;
		lk.wr_way = (state_q == LOOKUP) ? pick_way : way_q;
		lk.wr_tag = req_tag;
		// refill brings memory data, every other fill is the core's word
		lk.wr_data = (state_q == REFILL) ? mem_rd_data : wdata_q;
		// core writes leave the line dirty, refills leave it clean
		lk.wr_dirty = is_wr_q;
		lk.wr_line = ((state_q == LOOKUP) && is_wr_q && (lk.hit || lk.free_found)) ||
			((state_q == REFILL) && mem_last) ||
			(state_q == FILL_WRITE);
		lk.clr_dirty = (state_q == EVICT) && mem_last;
		lru.set = req_set;
		lru.touch = (state_q == LOOKUP);
		lru.touch_way = pick_way;
	end

	// state and memory countdown
	always_ff @(posedge clk) begin
		if (!rst) begin
			state_q <= IDLE;
			cnt_q <= '0;
			is_wr_q <= 1'b0;
		end else begin
			case (state_q)
				IDLE: begin
					if (accept) begin
						is_wr_q <= wr_en;
						state_q <= LOOKUP;
					end
				end
				LOOKUP: begin
					if (lk.hit || (is_wr_q && lk.free_found)) begin
						state_q <= RESPOND;
					end else if (victim_dirty) begin
						cnt_q <= lat_cnt_t'(`MEM_LAT - 1);
						state_q <= EVICT;
					end else if (is_wr_q) begin
						// clean victim, just overwrite it
						state_q <= FILL_WRITE;
					end else begin
						cnt_q <= lat_cnt_t'(`MEM_LAT - 1);
						state_q <= REFILL;
					end
				end
				EVICT: begin
					if (!mem_last) begin
						cnt_q <= cnt_q - 1'b1;
					end else if (is_wr_q) begin
						state_q <= FILL_WRITE;
					end else begin
						cnt_q <= lat_cnt_t'(`MEM_LAT - 1);
						state_q <= REFILL;
					end
				end
				REFILL: begin
					if (mem_last) begin
						state_q <= RESPOND;
					end else begin
						cnt_q <= cnt_q - 1'b1;
					end
				end
				FILL_WRITE: state_q <= RESPOND;
				RESPOND: state_q <= IDLE;
				default: state_q <= IDLE;
			endcase
		end
	end

	// request, way and read word
	always_ff @(posedge clk) begin
		if (accept) begin
			addr_q <= addr;
			wdata_q <= wr_data;
		end
		if (state_q == LOOKUP) begin
			way_q <= pick_way;
		end
		if ((state_q == LOOKUP) && lk.hit) begin
			rd_q <= lk.line_data;
		end else if ((state_q == REFILL) && mem_last) begin
			rd_q <= mem_rd_data;
		end
	end

	assign busy = (state_q != IDLE);
	assign valid = (state_q == RESPOND);
	assign rd_data = rd_q;
	// one strobe at a time, both held for the whole countdown
	assign mem_rd_en = (state_q == REFILL);
	assign mem_wr_en = (state_q == EVICT);
	// victim line address is its own tag with the set
	assign mem_addr = (state_q == EVICT) ? {lk.line_tag, req_set} : addr_q;
	assign mem_wr_data = lk.line_data;

endmodule

/* logic/dcache_top.sv */
module dcache_top import dcache_pkg::*; (
	input logic clk,
	input logic rst,
	// core side
	input logic rd_en,
	input logic wr_en,
	input addr_t addr,
	input data_t wr_data,
	output data_t rd_data,
	output logic busy,
	output logic valid,
	// memory side
	output logic mem_rd_en,
	output logic mem_wr_en,
	output addr_t mem_addr,
	output data_t mem_wr_data,
	input data_t mem_rd_data
);

	way_lookup_if lk ();
	plru_if lru ();

	// request FSM, drives every memory strobe
	dcache_ctrl u_ctrl (
		.clk (clk),
		.rst (rst),
		.rd_en (rd_en),
		.wr_en (wr_en),
		.addr (addr),
		.wr_data (wr_data),
		.rd_data (rd_data),
		.busy (busy),
		.valid (valid),
		.mem_rd_en (mem_rd_en),
		.mem_wr_en (mem_wr_en),
		.mem_addr (mem_addr),
		.mem_wr_data (mem_wr_data),
		.mem_rd_data (mem_rd_data),
		.lk (lk.ctrl),
		.lru (lru.ctrl)
	);

	// tags, state bits and data words
	line_store u_store (
		.clk (clk),
		.rst (rst),
		.lk (lk.store)
	);

	// replacement bits per set
	plru_tree u_plru (
		.clk (clk),
		.rst (rst),
		.lru (lru.tree)
	);

endmodule

/* verif/clk_gen.sv */
module clk_gen (
	output logic clk,
	output logic rst
);
	timeunit 1ns;
	timeprecision 100ps;

	// 20 ns period
	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// active low reset held for 16 cycles, released on a falling edge
	initial begin
		rst = 1'b0;
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst = 1'b1;
	end
endmodule

/* verif/dcache_tb.sv */
`include "dcache_cfg.svh"

module dcache_tb import dcache_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	logic clk;
	logic rst;
	logic rd_en;
	logic wr_en;
	addr_t addr;
	data_t wr_data;
	data_t rd_data;
	logic busy;
	logic valid;
	logic mem_rd_en;
	logic mem_wr_en;
	addr_t mem_addr;
	data_t mem_wr_data;
	data_t mem_rd_data;

	// memory model and burst bookkeeping
	data_t mem [1 << `ADDR_W];
	int rd_run;
	int wr_run;
	int rd_bursts;
	int wr_bursts;
	addr_t rd_addr0;
	addr_t wb_addr;
	data_t wb_data;

	// cases from the data file
	byte op_a [64];
	addr_t addr_a [64];
	data_t wdata_a [64];
	data_t exp_a [64];
	int nrd_a [64];
	int nwr_a [64];
	addr_t wba_a [64];
	data_t wbd_a [64];
	int n_cases;
	int errors;
	int failed_cases;
	int cycles;
	int limit;

	clk_gen u_clk (.*);
	dcache_top DUT (.*);

	task automatic check_word(input string name, input data_t got, input data_t exp);
		assert (got == exp) else begin
			$display("[ERROR] %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	// initial word is its address xor a fixed pattern
	initial begin
		for (int a = 0; a < (1 << `ADDR_W); a++) begin
			mem[a] = data_t'(a) ^ 32'hA5A50000;
		end
	end

	// word at mem_addr is always presented
	assign mem_rd_data = mem[mem_addr];

	// strobe length, stable address and data, write on last cycle
	always @(posedge clk) begin
		if (rst) begin
			assert (!(mem_rd_en && mem_wr_en)) else begin
				$display("memory read and write strobes were high together");
				errors++;
			end
			if (mem_rd_en) begin
				if (rd_run == 0) begin
					rd_bursts++;
					rd_addr0 = mem_addr;
				end
				check_word("mem_addr", data_t'(mem_addr), data_t'(rd_addr0));
				rd_run++;
			end else if (rd_run != 0) begin
				assert (rd_run == `MEM_LAT) else begin
					$display("memory read strobe was held for %0d cycles", rd_run);
					errors++;
				end
				rd_run = 0;
			end
			if (mem_wr_en) begin
				if (wr_run == 0) begin
					wr_bursts++;
					wb_addr = mem_addr;
					wb_data = mem_wr_data;
				end
				check_word("mem_addr", data_t'(mem_addr), data_t'(wb_addr));
				check_word("mem_wr_data", mem_wr_data, wb_data);
				wr_run++;
				if (wr_run == `MEM_LAT) begin
					mem[mem_addr] = mem_wr_data;
					$display("memory write %h <= %h", mem_addr, mem_wr_data);
				end
			end else if (wr_run != 0) begin
				assert (wr_run == `MEM_LAT) else begin
					$display("memory write strobe was held for %0d cycles", wr_run);
					errors++;
				end
				wr_run = 0;
			end
		end
	end

	// one operation per line
	// lines starting with # are skipped
	task automatic read_cases(output int ok);
		int fd;
		int n;
		string line;
		n_cases = 0;
		fd = $fopen("verif/dcache_cases.txt", "r");
		if (fd != 0) begin
			while ($fgets(line, fd) > 0) begin
				if (line.len() > 2 && line[0] != "#") begin
					n = $sscanf(line, "%c %h %h %h %d %d %h %h", op_a[n_cases],
						addr_a[n_cases], wdata_a[n_cases], exp_a[n_cases],
						nrd_a[n_cases], nwr_a[n_cases], wba_a[n_cases], wbd_a[n_cases]);
					if (n == 8) begin
						n_cases++;
					end
				end
			end
			$fclose(fd);
		end
		ok = (n_cases > 0);
	endtask

	task automatic run_case(input int i);
		int rd0;
		int wr0;
		int err0;
		byte op;
		op = op_a[i];
		err0 = errors;
		rd0 = rd_bursts;
		wr0 = wr_bursts;
		// random idle gap before the strobe
		repeat ($urandom % 4) @(negedge clk);
		addr = addr_a[i];
		wr_data = wdata_a[i];
		rd_en = (op == "R") || (op == "D");
		wr_en = (op == "W") || (op == "X") || (op == "D");
		@(negedge clk);
		rd_en = 1'b0;
		wr_en = 1'b0;
		if (op == "D") begin
			// rd_en with wr_en is no request at all
			repeat (4) begin
				assert (!busy && !valid) else begin
					$display("a request with rd_en and wr_en together was accepted");
					errors++;
				end
				@(negedge clk);
			end
		end else begin
			if (op == "X") begin
				// stray write with other data while busy
				// the DUT must drop it
				assert (busy) else begin
					$display("busy was low right after a request was accepted");
					errors++;
				end
				wr_en = 1'b1;
				wr_data = ~wdata_a[i];
				@(negedge clk);
				wr_en = 1'b0;
			end
			while (!valid) @(negedge clk);
			if (op == "R") begin
				check_word("rd_data", rd_data, exp_a[i]);
			end
			check_word("mem_rd_en bursts", data_t'(rd_bursts - rd0), data_t'(nrd_a[i]));
			check_word("mem_wr_en bursts", data_t'(wr_bursts - wr0), data_t'(nwr_a[i]));
			if (nwr_a[i] > 0) begin
				check_word("mem_addr", data_t'(wb_addr), data_t'(wba_a[i]));
				check_word("mem_wr_data", wb_data, wbd_a[i]);
			end
			@(negedge clk);
			assert (!valid && !busy) else begin
				$display("valid or busy stayed high after completion");
				errors++;
			end
		end
		if (errors != err0) begin
			failed_cases++;
		end
		$display("case %0d %c %h %s", i, op, addr_a[i], (errors == err0) ? "ok" : "failed");
	endtask

	// cycle limit from the case count
	initial begin
		wait (limit > 0);
		cycles = 0;
		while (cycles < limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout, the run did not finish within %0d cycles", limit);
		$display(">>> FAIL");
		$finish;
	end

	initial begin
		int ok;
		rd_en = 1'b0;
		wr_en = 1'b0;
		addr = '0;
		wr_data = '0;
		errors = 0;
		failed_cases = 0;
		rd_run = 0;
		wr_run = 0;
		rd_bursts = 0;
		wr_bursts = 0;
		void'($urandom(84));
		read_cases(ok);
		if (!ok) begin
			$display("no case could be read from verif/dcache_cases.txt");
			$display(">>> FAIL");
			$finish;
		end else begin
			limit = n_cases * (2 * `MEM_LAT + 6) + 40;
			wait (rst);
			@(negedge clk);
			for (int i = 0; i < n_cases; i++) begin
				run_case(i);
			end
			$display("cases %0d, failed %0d, errors %0d", n_cases, failed_cases, errors);
			if (errors == 0) begin
				$display(">>> PASS");
			end else begin
				$display(">>> FAIL");
			end
			$finish;
		end
	end
endmodule

/* verif/dcache_cases.txt */
# op addr wr_data rd_data rd_bursts wr_bursts wb_addr wb_data, all hex but the burst counts
# op R read, W write, D rd_en with wr_en, X write with a stray strobe while busy
R 013 00000000 a5a50013 1 0 000 00000000
R 013 00000000 a5a50013 0 0 000 00000000
W 025 11112222 00000000 0 0 000 00000000
R 025 00000000 11112222 0 0 000 00000000
W 009 aaaa0001 00000000 0 0 000 00000000
W 011 aaaa0002 00000000 0 0 000 00000000
W 019 aaaa0003 00000000 0 0 000 00000000
W 021 aaaa0004 00000000 0 0 000 00000000
R 009 00000000 aaaa0001 0 0 000 00000000
R 011 00000000 aaaa0002 0 0 000 00000000
R 019 00000000 aaaa0003 0 0 000 00000000
R 021 00000000 aaaa0004 0 0 000 00000000
W 009 bbbb0001 00000000 0 0 000 00000000
W 029 cccc0005 00000000 0 1 019 aaaa0003
R 019 00000000 aaaa0003 1 1 011 aaaa0002
R 009 00000000 bbbb0001 0 0 000 00000000
R 029 00000000 cccc0005 0 0 000 00000000
R 006 00000000 a5a50006 1 0 000 00000000
R 00e 00000000 a5a5000e 1 0 000 00000000
R 016 00000000 a5a50016 1 0 000 00000000
R 01e 00000000 a5a5001e 1 0 000 00000000
R 026 00000000 a5a50026 1 0 000 00000000
R 006 00000000 a5a50006 1 0 000 00000000
D 013 deadbeef 00000000 0 0 000 00000000
R 013 00000000 a5a50013 0 0 000 00000000
X 025 33334444 00000000 0 0 000 00000000
R 025 00000000 33334444 0 0 000 00000000

/* vlog.f */
+incdir+include
logic/dcache_pkg.sv
logic/dcache_if.sv
logic/line_store.sv
logic/plru_tree.sv
logic/dcache_ctrl.sv
logic/dcache_top.sv
verif/clk_gen.sv
verif/dcache_tb.sv
